//--- include/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Image geometry
`define CONV_IMG_W  32
`define CONV_IMG_H  32

// One address covers the whole image
`define CONV_ADDR_W 10

// Pixels and coefficients share a width
`define CONV_PIX_W  8

// Nine 16-bit products fit with margin
`define CONV_ACC_W  20

`endif

//--- hw/conv_pkg.sv
`default_nettype none

`include "conv_params.svh"

package conv_pkg;

    typedef logic signed [`CONV_PIX_W-1:0]  pix_t;
    typedef logic signed [`CONV_PIX_W-1:0]  coef_t;
    typedef logic        [`CONV_ADDR_W-1:0] addr_t;

    // Row-major 3x3 window, index 4 is the center
    typedef pix_t  [0:8] patch_t;
    typedef addr_t [0:8] patch_addr_t;

    typedef logic signed [`CONV_ACC_W-1:0]  acc_t;

endpackage

`default_nettype wire

//--- hw/conv_ifs.sv
`timescale 1ns/10ps
`default_nettype none

interface patch_addr_if
    import conv_pkg::*;
();
    patch_addr_t pixel_addr;
    logic        load;
    logic        load_full_patch; // Low means shift up one row

    modport ctrl (output pixel_addr, output load, output load_full_patch);
    modport latch (input pixel_addr, input load, input load_full_patch);
endinterface

interface patch_pix_if
    import conv_pkg::*;
();
    patch_t pixel;
    logic   load_done; // One cycle per new patch

    modport latch (output pixel, output load_done);
    modport mac (input pixel, input load_done);
endinterface

`default_nettype wire

//--- hw/image_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_params.svh"

module image_mem
    import conv_pkg::*;
(
    input  wire        clk,
    input  wire        we,
    input  wire addr_t wr_addr,
    input  wire pix_t  wr_data,
    input  wire addr_t addr,
    output pix_t       data_out
);

    localparam int DEPTH = `CONV_IMG_W * `CONV_IMG_H;

    pix_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after addr
    always_ff @(posedge clk)
    begin
        data_out <= mem[addr];
    end

endmodule

`default_nettype wire

//--- hw/patch_scan_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_params.svh"

module patch_scan_ctrl
    import conv_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        start,
    output logic       busy,
    output logic       done,
    patch_addr_if.ctrl addr_bus
);

    localparam int OUT_W = `CONV_IMG_W - 2;
    localparam int OUT_H = `CONV_IMG_H - 2;
    localparam int CNT_W = $clog2(`CONV_IMG_W);
    // Last issue to done: memory, load, latch, two MAC stages
    localparam int TAIL = 5;

    logic             run;
    logic [CNT_W-1:0] row_cnt;
    logic [CNT_W-1:0] col_cnt;
    logic             last_pos;
    logic             issue_q;
    logic             full_q;
    logic             load_q;
    logic             load_full_q;
    logic [TAIL-1:0]  tail;
    addr_t            base;
    patch_addr_t      addr_next;
    patch_addr_t      addr_q;

    assign last_pos = (row_cnt == OUT_H - 1) && (col_cnt == OUT_W - 1);
    assign base     = addr_t'(row_cnt * `CONV_IMG_W + col_cnt); // Top-left pixel

    always_comb
    begin
        for (int r = 0; r < 3; r++)
        begin
            for (int k = 0; k < 3; k++)
            begin
                addr_next[r*3+k] = base + addr_t'(r * `CONV_IMG_W + k);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (run)
        begin
            addr_q <= addr_next;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            run         <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
            row_cnt     <= '0;
            col_cnt     <= '0;
            issue_q     <= 1'b0;
            full_q      <= 1'b0;
            load_q      <= 1'b0;
            load_full_q <= 1'b0;
            tail        <= '0;
        end
        else
        begin
            issue_q     <= run;
            full_q      <= run && (row_cnt == 0); // Top of column
            load_q      <= issue_q;               // Memory read latency
            load_full_q <= full_q;
            tail        <= {tail[TAIL-2:0], run && last_pos};
            done        <= tail[TAIL-1];

            if (!busy && start)
            begin
                run  <= 1'b1;
                busy <= 1'b1;
            end
            else if (tail[TAIL-1])
            begin
                busy <= 1'b0;
            end

            // Column-major walk, row is the fast counter
            if (run)
            begin
                if (last_pos)
                begin
                    run     <= 1'b0;
                    row_cnt <= '0;
                    col_cnt <= '0;
                end
                else if (row_cnt == OUT_H - 1)
                begin
                    row_cnt <= '0;
                    col_cnt <= col_cnt + 1'b1;
                end
                else
                begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    assign addr_bus.pixel_addr      = addr_q;
    assign addr_bus.load            = load_q;
    assign addr_bus.load_full_patch = load_full_q;

endmodule

`default_nettype wire

//--- hw/patch_data_latch.sv
`timescale 1ns/10ps
`default_nettype none

module patch_data_latch
    import conv_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         mem_wr,
    input  wire addr_t  mem_wr_addr,
    input  wire pix_t   mem_wr_data,
    patch_addr_if.latch addr_bus,
    patch_pix_if.latch  pix_bus
);

    wire patch_t mem_data;
    patch_t      patch_q;
    logic        load_done_q;

    // One copy per window position so all nine read together
    for (genvar i = 0; i < 9; i++)
    begin : g_mem
        image_mem u_image_mem (
            .clk      (clk),
            .we       (mem_wr),
            .wr_addr  (mem_wr_addr),
            .wr_data  (mem_wr_data),
            .addr     (addr_bus.pixel_addr[i]),
            .data_out (mem_data[i])
        );
    end

    always_ff @(posedge clk)
    begin
        if (addr_bus.load)
        begin
            if (addr_bus.load_full_patch)
            begin
                patch_q <= mem_data;
            end
            else
            begin
                for (int i = 0; i < 6; i++)
                begin
                    patch_q[i] <= patch_q[i+3]; // Rows 1-2 move up
                end
                for (int i = 6; i < 9; i++)
                begin
                    patch_q[i] <= mem_data[i]; // New bottom row
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            load_done_q <= 1'b0;
        end
        else
        begin
            load_done_q <= addr_bus.load;
        end
    end

    assign pix_bus.pixel     = patch_q;
    assign pix_bus.load_done = load_done_q;

endmodule

`default_nettype wire

//--- hw/conv_mac.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_params.svh"

module conv_mac
    import conv_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        coef_wr,
    input  wire  [3:0] coef_idx,
    input  wire coef_t coef_data,
    patch_pix_if.mac   pix_bus,
    output logic       out_valid,
    output acc_t       out_data
);

    localparam int TAPS   = 9;
    localparam int PROD_W = 2 * `CONV_PIX_W;

    coef_t                    coef_q [TAPS];
    logic signed [PROD_W-1:0] prod_q [TAPS];
    acc_t                     sum_c;
    acc_t                     acc_q;
    logic [1:0]               vld_q;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < TAPS; i++)
            begin
                coef_q[i] <= '0;
            end
        end
        else if (coef_wr && (coef_idx < TAPS))
        begin
            coef_q[coef_idx] <= coef_data;
        end
    end

    // Stage 1
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < TAPS; i++)
        begin
            prod_q[i] <= $signed(pix_bus.pixel[i]) * coef_q[i];
        end
    end

    always_comb
    begin
        sum_c = '0;
        for (int i = 0; i < TAPS; i++)
        begin
            sum_c = sum_c + acc_t'(prod_q[i]); // Sign extended
        end
    end

    // Stage 2
    always_ff @(posedge clk)
    begin
        acc_q <= sum_c;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            vld_q <= '0;
        end
        else
        begin
            vld_q <= {vld_q[0], pix_bus.load_done};
        end
    end

    assign out_valid = vld_q[1];
    assign out_data  = acc_q;

endmodule

`default_nettype wire

//--- hw/conv_engine_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_engine_top
    import conv_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    // Image load, all nine copies at once
    input  wire        mem_wr,
    input  wire addr_t mem_wr_addr,
    input  wire pix_t  mem_wr_data,
    // Kernel load
    input  wire        coef_wr,
    input  wire  [3:0] coef_idx,
    input  wire coef_t coef_data,
    input  wire        start,
    output logic       busy,
    output logic       out_valid,
    output acc_t       out_data,
    output logic       done
);

    patch_addr_if u_addr_if ();
    patch_pix_if  u_pix_if ();

    patch_scan_ctrl u_patch_scan_ctrl (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .addr_bus (u_addr_if.ctrl)
    );

    patch_data_latch u_patch_data_latch (
        .clk         (clk),
        .rst         (rst),
        .mem_wr      (mem_wr),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .addr_bus    (u_addr_if.latch),
        .pix_bus     (u_pix_if.latch)
    );

    conv_mac u_conv_mac (
        .clk       (clk),
        .rst       (rst),
        .coef_wr   (coef_wr),
        .coef_idx  (coef_idx),
        .coef_data (coef_data),
        .pix_bus   (u_pix_if.mac),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- verif/conv_engine_assert.sv
`timescale 1ns/10ps
`default_nettype none

module conv_engine_assert (
    input wire clk,
    input wire rst,
    input wire busy,
    input wire done,
    input wire load,
    input wire load_full_patch,
    input wire load_done
);

    // Latch strobe is exactly one cycle behind load
    a_load_done_follows: assert property (@(posedge clk) disable iff (!rst)
        load_done == $past(load))
    else $error("load_done does not follow load by one cycle");

    a_full_with_load: assert property (@(posedge clk) disable iff (!rst)
        load_full_patch |-> load)
    else $error("load_full_patch high without load");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done |=> !done)
    else $error("done held longer than one cycle");

    a_no_load_idle: assert property (@(posedge clk) disable iff (!rst)
        $rose(load) |-> busy)
    else $error("load rose while the controller was idle");

endmodule

// Controller and latch strobes as seen at the top level
bind conv_engine_top conv_engine_assert u_conv_engine_assert (
    .clk             (clk),
    .rst             (rst),
    .busy            (busy),
    .done            (done),
    .load            (u_addr_if.load),
    .load_full_patch (u_addr_if.load_full_patch),
    .load_done       (u_pix_if.load_done)
);

`default_nettype wire

//--- verif/conv_engine_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_params.svh"

module conv_engine_tb
    import conv_pkg::*;
();

    localparam int IMG_W   = `CONV_IMG_W;
    localparam int OUT_W   = `CONV_IMG_W - 2;
    localparam int OUT_H   = `CONV_IMG_H - 2;
    localparam int NPIX    = `CONV_IMG_W * `CONV_IMG_H;
    localparam int NOUT    = OUT_W * OUT_H;
    localparam int TSTEP   = 1;    // Drive delay after rising edge
    localparam int TIMEOUT = 2000; // Cycles per scan

    logic  clk = 1'b0;
    logic  rst;
    logic  mem_wr;
    addr_t mem_wr_addr;
    pix_t  mem_wr_data;
    logic  coef_wr;
    logic  [3:0] coef_idx;
    coef_t coef_data;
    logic  start;
    logic  busy;
    logic  out_valid;
    acc_t  out_data;
    logic  done;

    integer seed;
    int     img [NPIX];   // Model image
    int     kern [9];     // Model kernel, row-major
    int     errors;
    int     failed_tests;
    bit     timed_out;

    conv_engine_top u_conv_engine_top (
        .clk         (clk),
        .rst         (rst),
        .mem_wr      (mem_wr),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .coef_wr     (coef_wr),
        .coef_idx    (coef_idx),
        .coef_data   (coef_data),
        .start       (start),
        .busy        (busy),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .done        (done)
    );

    always #50 clk = ~clk;

    task automatic write_image();
        for (int a = 0; a < NPIX; a++)
        begin
            @(posedge clk);
            #TSTEP;
            mem_wr      = 1'b1;
            mem_wr_addr = addr_t'(a);
            mem_wr_data = pix_t'(img[a]);
        end
        @(posedge clk);
        #TSTEP;
        mem_wr = 1'b0;
    endtask

    task automatic write_kernel();
        for (int i = 0; i < 9; i++)
        begin
            @(posedge clk);
            #TSTEP;
            coef_wr   = 1'b1;
            coef_idx  = 4'(i);
            coef_data = coef_t'(kern[i]);
        end
        @(posedge clk);
        #TSTEP;
        coef_wr = 1'b0;
    endtask

    task automatic random_image();
        for (int a = 0; a < NPIX; a++)
        begin
            img[a] = pix_t'($random(seed));
        end
    endtask

    task automatic random_kernel();
        for (int i = 0; i < 9; i++)
        begin
            kern[i] = coef_t'($random(seed));
        end
    endtask

    // Signed sum over the window with top-left pixel at (r, c)
    function automatic int model_sum(int r, int c);
        int s;
        s = 0;
        for (int i = 0; i < 3; i++)
        begin
            for (int j = 0; j < 3; j++)
            begin
                s += img[(r + i) * IMG_W + c + j] * kern[i * 3 + j];
            end
        end
        return s;
    endfunction

    task automatic check_low(input string name, input logic val, input string when);
        if (val !== 1'b0)
        begin
            $display("MISMATCH at %0t: %s %s expected 0 actual %b", $time, name, when, val);
            errors++;
        end
    endtask

    task automatic check_idle(input string when);
        check_low("busy", busy, when);
        check_low("out_valid", out_valid, when);
        check_low("done", done, when);
    endtask

    // One start pulse, then score every output until done
    task automatic run_scan(output int first_lat);
        int idx;
        int cyc;
        int exp_v;
        int act_v;
        bit prev_valid;
        bit done_seen;
        first_lat  = -1;
        idx        = 0;
        cyc        = 0;
        prev_valid = 1'b0;
        done_seen  = 1'b0;
        if (timed_out)
        begin
            return;
        end
        @(posedge clk);
        #TSTEP;
        start = 1'b1;
        @(posedge clk); // Start sampled here
        #TSTEP;
        start = 1'b0;
        while (!done_seen && cyc < TIMEOUT)
        begin
            @(negedge clk);
            if (out_valid)
            begin
                if (idx == 0)
                begin
                    first_lat = cyc;
                end
                else if (!prev_valid)
                begin
                    $display("ERROR at %0t: gap in out_valid before output %0d", $time, idx);
                    errors++;
                end
                if (busy !== 1'b1)
                begin
                    $display("MISMATCH at %0t: busy at output %0d expected 1 actual %b",
                             $time, idx, busy);
                    errors++;
                end
                if (idx < NOUT)
                begin
                    exp_v = model_sum(idx % OUT_H, idx / OUT_H); // Column-major
                    act_v = out_data;
                    if (act_v != exp_v)
                    begin
                        $display("MISMATCH at %0t: out_data (r=%0d c=%0d) expected %0d actual %0d",
                                 $time, idx % OUT_H, idx / OUT_H, exp_v, act_v);
                        errors++;
                    end
                end
                idx++;
            end
            if (done)
            begin
                done_seen = 1'b1;
                if (!prev_valid)
                begin
                    $display("ERROR at %0t: done did not follow the last out_valid", $time);
                    errors++;
                end
                if (busy !== 1'b0)
                begin
                    $display("MISMATCH at %0t: busy in done cycle expected 0 actual %b",
                             $time, busy);
                    errors++;
                end
            end
            prev_valid = out_valid;
            cyc++;
        end
        if (!done_seen)
        begin
            $display("ERROR at %0t: timeout, done never came after start", $time);
            errors++;
            timed_out = 1'b1;
        end
        if (idx != NOUT)
        begin
            $display("MISMATCH at %0t: out_valid count expected %0d actual %0d",
                     $time, NOUT, idx);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors != errs_before)
        begin
            failed_tests++;
        end
        $display("Test %0d %s: %0d errors", num, name, errors - errs_before);
    endtask

    initial
    begin
        int e0;
        int lat;
        seed         = 52947;
        errors       = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        rst          = 1'b0;
        mem_wr       = 1'b0;
        mem_wr_addr  = '0;
        mem_wr_data  = '0;
        coef_wr      = 1'b0;
        coef_idx     = '0;
        coef_data    = '0;
        start        = 1'b0;

        e0 = errors;
        repeat (10)
        begin
            @(negedge clk);
            check_idle("during reset");
        end
        @(posedge clk);
        #TSTEP;
        rst = 1'b1;
        repeat (3)
        begin
            @(negedge clk);
            check_idle("after reset");
        end
        report_test(1, "reset state", e0);

        e0 = errors;
        random_image();
        write_image();
        for (int i = 0; i < 9; i++)
        begin
            kern[i] = (i == 4) ? 1 : 0; // Center tap only
        end
        write_kernel();
        run_scan(lat);
        report_test(2, "identity kernel", e0);

        e0 = errors;
        random_kernel();
        write_kernel();
        run_scan(lat);
        report_test(3, "random kernel and image", e0);

        e0 = errors;
        for (int a = 0; a < NPIX; a++)
        begin
            img[a] = -128;
        end
        for (int i = 0; i < 9; i++)
        begin
            kern[i] = -128;
        end
        write_image();
        write_kernel();
        run_scan(lat);
        for (int a = 0; a < NPIX; a++)
        begin
            img[a] = 127;
        end
        for (int i = 0; i < 9; i++)
        begin
            kern[i] = (i % 2 == 1) ? -128 : 127;
        end
        write_image();
        write_kernel();
        run_scan(lat);
        report_test(4, "extremes", e0);

        e0 = errors;
        random_image();
        write_image();
        for (int pass = 0; pass < 2; pass++)
        begin
            random_kernel(); // Image stays, kernel changes
            write_kernel();
            run_scan(lat);
            if (!timed_out && lat != 5)
            begin
                $display("MISMATCH at %0t: first out_valid latency expected 5 actual %0d",
                         $time, lat);
                errors++;
            end
        end
        report_test(5, "timing and repeat", e0);

        $display("Summary: 5 tests, %0d failed, %0d errors", failed_tests, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hw/conv_pkg.sv
hw/conv_ifs.sv
hw/image_mem.sv
hw/patch_scan_ctrl.sv
hw/patch_data_latch.sv
hw/conv_mac.sv
hw/conv_engine_top.sv
verif/conv_engine_assert.sv
verif/conv_engine_tb.sv
